// File: common/barrett_pkg.sv
`default_nettype none

package barrett_pkg;

  // ==============================
  // Datapath
  // ==============================
  localparam int DATA_W_DEFAULT = 32;  // One register word

  // ==============================
  // Register map, byte offsets
  // ==============================
  localparam logic [4:0] ADDR_CTRL   = 5'h00;  // Bit 0 starts a reduction
  localparam logic [4:0] ADDR_STATUS = 5'h04;  // Bit 0 busy, bit 1 sticky done
  localparam logic [4:0] ADDR_X      = 5'h08;
  localparam logic [4:0] ADDR_Q      = 5'h0C;
  localparam logic [4:0] ADDR_QBL    = 5'h10;  // Bit length k of q
  localparam logic [4:0] ADDR_MU     = 5'h14;  // floor(2^2k / q)
  localparam logic [4:0] ADDR_RESULT = 5'h18;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: src/serial_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

module serial_multiplier import barrett_pkg::*; #(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  start_i,
  input  wire [DATA_W-1:0]     a_i,
  input  wire [DATA_W-1:0]     b_i,
  output logic                 done_o,
  output logic [2*DATA_W-1:0]  product_o
);

  localparam int CNT_W = $clog2(DATA_W + 1);

  logic                 running_q;
  logic [CNT_W-1:0]     cnt_q;      // Multiplier bits still to process
  logic [2*DATA_W-1:0]  mcand_q;    // Shifted left once per step
  logic [DATA_W-1:0]    mplier_q;   // Shifted right once per step
  logic [2*DATA_W-1:0]  acc_q;

  // ==============================
  // Sequencing
  // ==============================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        running_q <= 1'b1;
        cnt_q     <= CNT_W'(DATA_W);
      end else if (running_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CNT_W'(1)) begin
          running_q <= 1'b0;
          done_o    <= 1'b1;  // Last add lands on this edge
        end
      end
    end
  end

  // ==============================
  // Shift-add datapath
  // ==============================
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      mcand_q  <= {{DATA_W{1'b0}}, a_i};
      mplier_q <= b_i;
      acc_q    <= '0;
    end else if (running_q) begin
      if (mplier_q[0]) acc_q <= acc_q + mcand_q;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign product_o = acc_q;  // Held until the next start

endmodule

`default_nettype wire

// File: barrett/barrett_reducer.sv
`timescale 1ns/1ns
`default_nettype none

module barrett_reducer import barrett_pkg::*; #(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  start_i,
  input  wire [DATA_W-1:0]     x_i,
  input  wire [DATA_W-1:0]     q_i,
  input  wire [DATA_W-1:0]     qbl_i,
  input  wire [DATA_W-1:0]     mu_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic [DATA_W-1:0]    result_o,
  output logic                 mul_start_o,
  output logic [DATA_W-1:0]    mul_a_o,
  output logic [DATA_W-1:0]    mul_b_o,
  input  wire                  mul_done_i,
  input  wire [2*DATA_W-1:0]   mul_product_i
);

  typedef enum logic [2:0] {
    IDLE, PRODUCT_XMU, SHIFT, PRODUCT_TQ, SUBTRACT, CORRECT, DONE
  } state_t;

  state_t state_q, state_d;

  logic [DATA_W-1:0] x_q, q_q, qbl_q, mu_q;  // Operands latched at start
  logic [DATA_W-1:0] t_q;                    // Quotient estimate
  logic [DATA_W-1:0] rem_q;
  logic              mul_start_q;
  logic              corr_cnt_q;             // Set after the first correction
  logic [DATA_W-1:0] diff;
  logic [DATA_W-1:0] rem_sub;

  // x - t*q is below 2^DATA_W, so the low product half is enough
  assign diff    = x_q - mul_product_i[DATA_W-1:0];
  assign rem_sub = rem_q - q_q;

  // ==============================
  // State machine
  // ==============================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:        if (start_i) state_d = PRODUCT_XMU;
      PRODUCT_XMU: if (mul_done_i) state_d = SHIFT;
      SHIFT:       state_d = PRODUCT_TQ;
      PRODUCT_TQ:  if (mul_done_i) state_d = SUBTRACT;
      SUBTRACT:    state_d = (diff >= q_q) ? CORRECT : DONE;
      CORRECT: begin
        if (rem_sub < q_q || corr_cnt_q) state_d = DONE;  // At most two passes
      end
      DONE:        state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      mul_start_q <= 1'b0;
      corr_cnt_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      mul_start_q <= (state_q == IDLE && start_i) || (state_q == SHIFT);
      if (state_q == SUBTRACT) corr_cnt_q <= 1'b0;
      else if (state_q == CORRECT) corr_cnt_q <= 1'b1;
    end
  end

  // ==============================
  // Datapath
  // ==============================
  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: begin
        if (start_i) begin
          x_q   <= x_i;
          q_q   <= q_i;
          qbl_q <= qbl_i;
          mu_q  <= mu_i;
        end
      end
      SHIFT:    t_q   <= DATA_W'(mul_product_i >> {qbl_q, 1'b0});  // Divide by 2^2k
      SUBTRACT: rem_q <= diff;
      CORRECT:  rem_q <= rem_sub;
      default: ;
    endcase
  end

  // Multiplier operands follow the product being formed
  assign mul_start_o = mul_start_q;
  assign mul_a_o     = (state_q == PRODUCT_TQ) ? t_q : x_q;
  assign mul_b_o     = (state_q == PRODUCT_TQ) ? q_q : mu_q;

  assign busy_o   = (state_q != IDLE) && (state_q != DONE);  // Drops as done rises
  assign done_o   = (state_q == DONE);
  assign result_o = rem_q;

endmodule

`default_nettype wire

// File: src/barrett_regs.sv
`timescale 1ns/1ns
`default_nettype none

module barrett_regs import barrett_pkg::*; #(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input  wire                clk_i,
  input  wire                rst_ni,
  // AXI4-Lite slave
  input  wire [4:0]          s_awaddr_i,
  input  wire                s_awvalid_i,
  output logic               s_awready_o,
  input  wire [31:0]         s_wdata_i,
  input  wire                s_wvalid_i,
  output logic               s_wready_o,
  output logic [1:0]         s_bresp_o,
  output logic               s_bvalid_o,
  input  wire                s_bready_i,
  input  wire [4:0]          s_araddr_i,
  input  wire                s_arvalid_i,
  output logic               s_arready_o,
  output logic [31:0]        s_rdata_o,
  output logic [1:0]         s_rresp_o,
  output logic               s_rvalid_o,
  input  wire                s_rready_i,
  // Reducer side
  output logic [DATA_W-1:0]  x_o,
  output logic [DATA_W-1:0]  q_o,
  output logic [DATA_W-1:0]  qbl_o,
  output logic [DATA_W-1:0]  mu_o,
  output logic               start_o,
  input  wire                busy_i,
  input  wire                done_i,
  input  wire [DATA_W-1:0]   result_i
);

  logic              wr_en, rd_en;
  logic              wr_ok, rd_ok;
  logic [31:0]       rd_data;
  logic [DATA_W-1:0] x_q, q_q, qbl_q, mu_q, result_q;
  logic              done_q;   // Sticky done
  logic              start_q;

  // ==============================
  // Handshake and decode
  // ==============================
  assign wr_en = s_awvalid_i && s_wvalid_i && !s_bvalid_o;  // Address and data together
  assign rd_en = s_arvalid_i && !s_rvalid_o;

  assign s_awready_o = wr_en;
  assign s_wready_o  = wr_en;
  assign s_arready_o = rd_en;

  always_comb begin
    case (s_awaddr_i)
      ADDR_CTRL, ADDR_X, ADDR_Q, ADDR_QBL, ADDR_MU: wr_ok = 1'b1;
      default: wr_ok = 1'b0;  // STATUS, RESULT and holes
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b1;
    case (s_araddr_i)
      ADDR_CTRL:   rd_data = '0;  // Start bit self-clears
      ADDR_STATUS: rd_data[1:0] = {done_q, busy_i};
      ADDR_X:      rd_data[DATA_W-1:0] = x_q;
      ADDR_Q:      rd_data[DATA_W-1:0] = q_q;
      ADDR_QBL:    rd_data[DATA_W-1:0] = qbl_q;
      ADDR_MU:     rd_data[DATA_W-1:0] = mu_q;
      ADDR_RESULT: rd_data[DATA_W-1:0] = result_q;
      default:     rd_ok = 1'b0;
    endcase
  end

  // ==============================
  // Registers
  // ==============================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_q        <= '0;
      q_q        <= '0;
      qbl_q      <= '0;
      mu_q       <= '0;
      result_q   <= '0;
      done_q     <= 1'b0;
      start_q    <= 1'b0;
      s_bvalid_o <= 1'b0;
      s_bresp_o  <= RESP_OKAY;
      s_rvalid_o <= 1'b0;
      s_rresp_o  <= RESP_OKAY;
      s_rdata_o  <= '0;
    end else begin
      start_q <= wr_en && (s_awaddr_i == ADDR_CTRL) && s_wdata_i[0];  // One-cycle pulse
      if (wr_en) begin
        case (s_awaddr_i)
          ADDR_X:   x_q   <= s_wdata_i[DATA_W-1:0];
          ADDR_Q:   q_q   <= s_wdata_i[DATA_W-1:0];
          ADDR_QBL: qbl_q <= s_wdata_i[DATA_W-1:0];
          ADDR_MU:  mu_q  <= s_wdata_i[DATA_W-1:0];
          default: ;
        endcase
      end
      // A new start wins over a coinciding done
      if (wr_en && (s_awaddr_i == ADDR_CTRL) && s_wdata_i[0]) done_q <= 1'b0;
      else if (done_i) done_q <= 1'b1;
      if (done_i) result_q <= result_i;

      if (wr_en) begin
        s_bvalid_o <= 1'b1;
        s_bresp_o  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end

      if (rd_en) begin
        s_rvalid_o <= 1'b1;
        s_rdata_o  <= rd_data;
        s_rresp_o  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;  // Data held while stalled
      end
    end
  end

  assign x_o     = x_q;
  assign q_o     = q_q;
  assign qbl_o   = qbl_q;
  assign mu_o    = mu_q;
  assign start_o = start_q;

endmodule

`default_nettype wire

// File: src/barrett_top.sv
`timescale 1ns/1ns
`default_nettype none

module barrett_top import barrett_pkg::*; #(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input  wire         clk_i,
  input  wire         rst_ni,
  input  wire [4:0]   s_awaddr_i,
  input  wire         s_awvalid_i,
  output logic        s_awready_o,
  input  wire [31:0]  s_wdata_i,
  input  wire         s_wvalid_i,
  output logic        s_wready_o,
  output logic [1:0]  s_bresp_o,
  output logic        s_bvalid_o,
  input  wire         s_bready_i,
  input  wire [4:0]   s_araddr_i,
  input  wire         s_arvalid_i,
  output logic        s_arready_o,
  output logic [31:0] s_rdata_o,
  output logic [1:0]  s_rresp_o,
  output logic        s_rvalid_o,
  input  wire         s_rready_i
);

  logic [DATA_W-1:0]   x, q, qbl, mu, result;
  logic                start, busy, done;
  logic                mul_start, mul_done;
  logic [DATA_W-1:0]   mul_a, mul_b;
  logic [2*DATA_W-1:0] mul_product;

  // ==============================
  // Register block
  // ==============================
  barrett_regs #(.DATA_W(DATA_W)) u_regs (
    .clk_i, .rst_ni,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o,
    .s_wdata_i, .s_wvalid_i, .s_wready_o,
    .s_bresp_o, .s_bvalid_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .x_o(x), .q_o(q), .qbl_o(qbl), .mu_o(mu),
    .start_o(start), .busy_i(busy), .done_i(done), .result_i(result)
  );

  // ==============================
  // Reducer and shared multiplier
  // ==============================
  barrett_reducer #(.DATA_W(DATA_W)) u_reducer (
    .clk_i, .rst_ni,
    .start_i(start), .x_i(x), .q_i(q), .qbl_i(qbl), .mu_i(mu),
    .busy_o(busy), .done_o(done), .result_o(result),
    .mul_start_o(mul_start), .mul_a_o(mul_a), .mul_b_o(mul_b),
    .mul_done_i(mul_done), .mul_product_i(mul_product)
  );

  serial_multiplier #(.DATA_W(DATA_W)) u_mult (
    .clk_i, .rst_ni,
    .start_i(mul_start), .a_i(mul_a), .b_i(mul_b),
    .done_o(mul_done), .product_o(mul_product)
  );

endmodule

`default_nettype wire

// File: test/barrett_properties.sv
`timescale 1ns/1ns
`default_nettype none

module barrett_properties import barrett_pkg::*; #(
  parameter int DATA_W = DATA_W_DEFAULT
) (
  input wire              clk_i,
  input wire              rst_ni,
  input wire              s_bvalid_i,
  input wire              s_bready_i,
  input wire [1:0]        s_bresp_i,
  input wire              s_rvalid_i,
  input wire              s_rready_i,
  input wire [31:0]       s_rdata_i,
  input wire [1:0]        s_rresp_i,
  input wire              busy_i,
  input wire              done_i,
  input wire [DATA_W-1:0] result_i,
  input wire [DATA_W-1:0] q_latched_i
);

  int failures = 0;  // Read by the testbench at the end

  // ==============================
  // AXI response channels
  // ==============================
  bresp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_bvalid_i && !s_bready_i |=> s_bvalid_i && $stable(s_bresp_i))
    else begin
      failures++;
      $error("Write response dropped or changed before acceptance");
    end

  rdata_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_rvalid_i && !s_rready_i |=> s_rvalid_i && $stable(s_rdata_i) && $stable(s_rresp_i))
    else begin
      failures++;
      $error("Read data dropped or changed before acceptance");
    end

  // ==============================
  // Reducer
  // ==============================
  busy_ends_with_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_i) |-> done_i)
    else begin
      failures++;
      $error("Busy fell without done");
    end

  result_below_q: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> result_i < q_latched_i)
    else begin
      failures++;
      $error("Result not below q at done");
    end

endmodule

`default_nettype wire

// File: test/barrett_tb.sv
`timescale 1ns/1ns
`default_nettype none

module barrett_tb import barrett_pkg::*;;

  localparam int HANDSHAKE_LIMIT = 50;   // Cycles per channel handshake
  localparam int POLL_LIMIT      = 100;  // STATUS reads per reduction

  logic        clk_i, rst_ni;
  logic [4:0]  s_awaddr_i, s_araddr_i;
  logic        s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
  logic [31:0] s_wdata_i;
  logic        s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
  logic [1:0]  s_bresp_o, s_rresp_o;
  logic [31:0] s_rdata_o;

  int          seed = 17;
  int          errors = 0;
  int          timeouts = 0;
  logic [4:0]  operand_addr [4] = '{ADDR_X, ADDR_Q, ADDR_QBL, ADDR_MU};
  logic [31:0] rd, value, x, q;
  int          k;

  barrett_top #(.DATA_W(DATA_W_DEFAULT)) dut (.*);

  bind barrett_top barrett_properties #(.DATA_W(DATA_W)) u_props (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .s_bvalid_i(s_bvalid_o), .s_bready_i(s_bready_i), .s_bresp_i(s_bresp_o),
    .s_rvalid_i(s_rvalid_o), .s_rready_i(s_rready_i), .s_rdata_i(s_rdata_o),
    .s_rresp_i(s_rresp_o),
    .busy_i(busy), .done_i(done), .result_i(result), .q_latched_i(u_reducer.q_q)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
    assert (actual === expected) else begin
      errors++;
      $display("ERROR at %0t ns: %s got 0x%08h, expected 0x%08h", $time, what, actual,
               expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out at %0t ns waiting for %s", $time, what);
  endtask

  // ==============================
  // AXI4-Lite master
  // ==============================
  task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    int cycles;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!s_awready_o && cycles < HANDSHAKE_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!s_awready_o) begin
      report_timeout("write address and data acceptance");
    end else begin
      expect_equal({31'b0, s_wready_o}, 32'h1, "wready alongside awready");
    end
    @(posedge clk_i);
    #1;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    cycles = 0;
    @(negedge clk_i);
    while (!s_bvalid_o && cycles < HANDSHAKE_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!s_bvalid_o) report_timeout("the write response");
    expect_equal(32'(s_bresp_o), 32'(exp_resp), $sformatf("write response at 0x%02h", addr));
    @(posedge clk_i);
    #1;
    s_bready_i = 1'b1;
    @(posedge clk_i);
    #1;
    s_bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [4:0] addr, input logic [1:0] exp_resp,
                          input int stall, output logic [31:0] data);
    int cycles;
    logic [31:0] held;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!s_arready_o && cycles < HANDSHAKE_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!s_arready_o) report_timeout("read address acceptance");
    @(posedge clk_i);
    #1;
    s_arvalid_i = 1'b0;
    cycles = 0;
    @(negedge clk_i);
    while (!s_rvalid_o && cycles < HANDSHAKE_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!s_rvalid_o) report_timeout("read data");
    held = s_rdata_o;
    repeat (stall) begin  // rready stays low here
      @(negedge clk_i);
      expect_equal({31'b0, s_rvalid_o}, 32'h1, "rvalid while stalled");
      expect_equal(s_rdata_o, held, "rdata while stalled");
    end
    expect_equal(32'(s_rresp_o), 32'(exp_resp), $sformatf("read response at 0x%02h", addr));
    data = s_rdata_o;
    @(posedge clk_i);
    #1;
    s_rready_i = 1'b1;
    @(posedge clk_i);
    #1;
    s_rready_i = 1'b0;
  endtask

  // ==============================
  // Reference model and sequences
  // ==============================
  function automatic logic [31:0] barrett_mu(input logic [31:0] modulus, input int bits);
    logic [63:0] num;
    num = 64'd1 << (2 * bits);
    return 32'(num / modulus);
  endfunction

  task automatic random_operands(output logic [31:0] xr, output logic [31:0] qr,
                                 output int kr);
    logic [63:0] q_sq;
    kr   = 8 + ({$random(seed)} % 9);  // Keeps q squared inside one word
    qr   = ({$random(seed)} & ((32'd1 << kr) - 1)) | (32'd1 << (kr - 1));
    q_sq = 64'(qr) * 64'(qr);
    xr   = 32'({$random(seed)} % q_sq);
  endtask

  task automatic load_operands(input logic [31:0] xl, input logic [31:0] ql, input int kl);
    axi_write(ADDR_X, xl, RESP_OKAY);
    axi_write(ADDR_Q, ql, RESP_OKAY);
    axi_write(ADDR_QBL, 32'(kl), RESP_OKAY);
    axi_write(ADDR_MU, barrett_mu(ql, kl), RESP_OKAY);
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < POLL_LIMIT) begin
      axi_read(ADDR_STATUS, RESP_OKAY, 0, status);
      polls++;
    end
    if (!status[1]) report_timeout("the reduction to finish");
  endtask

  task automatic run_reduction(input logic [31:0] xr, input logic [31:0] qr, input int kr);
    logic [31:0] result;
    load_operands(xr, qr, kr);
    axi_write(ADDR_CTRL, 32'h1, RESP_OKAY);
    wait_done();
    axi_read(ADDR_RESULT, RESP_OKAY, 0, result);
    expect_equal(result, xr % qr, $sformatf("0x%08h mod 0x%08h", xr, qr));
  endtask

  initial begin
    rst_ni      = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    for (int i = 0; i < 4; i++) begin  // Operand readback
      value = $random(seed);
      axi_write(operand_addr[i], value, RESP_OKAY);
      axi_read(operand_addr[i], RESP_OKAY, 0, rd);
      expect_equal(rd, value, "operand readback");
    end

    repeat (20) begin
      random_operands(x, q, k);
      run_reduction(x, q, k);
    end
    run_reduction(32'h0000_FFF0, 32'h0000_FFF1, 16);  // x below q
    run_reduction(32'h0000_FFF1 * 32'h0000_FFF1 - 1, 32'h0000_FFF1, 16);
    run_reduction(32'h0000_B3 * 32'h0000_B3 - 1, 32'h0000_00B3, 8);

    // ==============================
    // Sticky done and start while busy
    // ==============================
    x = 32'h7654_3210;
    q = 32'h0000_C351;
    load_operands(x, q, 16);
    axi_write(ADDR_CTRL, 32'h1, RESP_OKAY);
    axi_read(ADDR_STATUS, RESP_OKAY, 0, rd);
    expect_equal(rd, 32'h1, "STATUS right after start");
    axi_write(ADDR_X, 32'h1234_5678, RESP_OKAY);
    axi_write(ADDR_CTRL, 32'h1, RESP_OKAY);  // Reducer is busy and ignores this
    wait_done();
    axi_read(ADDR_STATUS, RESP_OKAY, 0, rd);
    expect_equal(rd, 32'h2, "STATUS after completion");
    axi_read(ADDR_RESULT, RESP_OKAY, 0, rd);
    expect_equal(rd, x % q, "result of the first start");

    axi_write(5'h1C, 32'hDEAD_BEEF, RESP_SLVERR);
    axi_read(5'h1C, RESP_SLVERR, 0, rd);
    axi_write(ADDR_RESULT, 32'hFFFF_FFFF, RESP_SLVERR);
    axi_write(ADDR_STATUS, 32'hFFFF_FFFF, RESP_SLVERR);
    axi_read(ADDR_X, RESP_OKAY, 0, rd);
    expect_equal(rd, 32'h1234_5678, "X after rejected writes");
    axi_read(ADDR_Q, RESP_OKAY, 0, rd);
    expect_equal(rd, q, "Q after rejected writes");
    axi_read(ADDR_QBL, RESP_OKAY, 0, rd);
    expect_equal(rd, 32'd16, "QBL after rejected writes");
    axi_read(ADDR_MU, RESP_OKAY, 0, rd);
    expect_equal(rd, barrett_mu(q, 16), "MU after rejected writes");
    axi_read(ADDR_RESULT, RESP_OKAY, 6, rd);  // Stalled read channel
    expect_equal(rd, x % q, "RESULT after rejected writes");

    $display("Finished with %0d errors, %0d timeouts, %0d property failures", errors,
             timeouts, dut.u_props.failures);
    if (errors == 0 && timeouts == 0 && dut.u_props.failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/barrett_pkg.sv
src/serial_multiplier.sv
barrett/barrett_reducer.sv
src/barrett_regs.sv
src/barrett_top.sv
test/barrett_properties.sv
test/barrett_tb.sv
